// ==== hdl/pod_pkg.sv ====
// pod shared definitions
`default_nettype none

package pod_pkg;

  // compute mesh size
  localparam int NUM_TILES_X = 2;
  localparam int NUM_TILES_Y = 2;

  localparam int X_CORD_WIDTH = 2;
  localparam int Y_CORD_WIDTH = 2;

  // cache rows sit outside the compute rows 1 and 2
  localparam logic [Y_CORD_WIDTH-1:0] Y_NORTH_VC = 2'd0;
  localparam logic [Y_CORD_WIDTH-1:0] Y_SOUTH_VC = 2'd3;

  // x codes of the pod edge ports
  localparam logic [X_CORD_WIDTH-1:0] X_EDGE_WEST = 2'd2;
  localparam logic [X_CORD_WIDTH-1:0] X_EDGE_EAST = 2'd3;

  localparam int ADDR_WIDTH = 4;
  localparam int DATA_WIDTH = 16;
  localparam int VC_WORDS   = 16;

  // link buffering and credits
  localparam int FIFO_DEPTH     = 4;
  localparam int FIFO_PTR_WIDTH = 2;
  localparam int CREDIT_WIDTH   = 3;

  typedef enum logic [1:0] {
    OP_STORE = 2'd0,
    OP_LOAD  = 2'd1,
    OP_REPLY = 2'd2
  } op_e;

  // router port index
  typedef enum logic [1:0] {
    DIR_N = 2'd0,
    DIR_S = 2'd1,
    DIR_E = 2'd2,
    DIR_W = 2'd3
  } dir_e;

  typedef struct packed {
    op_e                     op;
    logic [X_CORD_WIDTH-1:0] dest_x;
    logic [Y_CORD_WIDTH-1:0] dest_y;
    logic [X_CORD_WIDTH-1:0] src_x;
    logic [Y_CORD_WIDTH-1:0] src_y;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH-1:0]   data;
  } packet_t;

endpackage

`default_nettype wire

// ==== hdl/credit_fifo.sv ====
// link input buffer
`timescale 1ns/10ps
`default_nettype none

module credit_fifo (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             valid_i,
  input  pod_pkg::packet_t data_i,
  input  logic             deq_i,
  output logic             valid_o,
  output pod_pkg::packet_t data_o,
  output logic             credit_o
);
  import pod_pkg::*;

  packet_t                   mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_WIDTH-1:0] wr_ptr_q;
  logic [FIFO_PTR_WIDTH-1:0] rd_ptr_q;
  logic [FIFO_PTR_WIDTH:0]   count_q;
  logic                      push;
  logic                      pop;

  // sender only pushes with a credit in hand, so no full check
  assign push = valid_i;
  assign pop  = deq_i && (count_q != '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + push - pop;
      // one credit back per removed entry
      credit_o <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

// ==== hdl/mesh_router.sv ====
// xy mesh router
`timescale 1ns/10ps
`default_nettype none

module mesh_router #(
  parameter logic [pod_pkg::X_CORD_WIDTH-1:0] TILE_X = 2'd0,
  parameter logic [pod_pkg::Y_CORD_WIDTH-1:0] TILE_Y = 2'd1
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic             [3:0] valid_i,
  input  pod_pkg::packet_t [3:0] data_i,
  output logic             [3:0] credit_o,
  output logic             [3:0] valid_o,
  output pod_pkg::packet_t [3:0] data_o,
  input  logic             [3:0] credit_i
);
  import pod_pkg::*;

  logic    [3:0]      head_valid;
  packet_t [3:0]      head_data;
  dir_e               head_dir [4];
  logic    [3:0]      deq;
  // indexed [output][input]
  logic    [3:0][3:0] req;
  logic    [3:0][3:0] gnt;

  // x first, then y
  function automatic dir_e route_dir(packet_t pkt);
    dir_e dir;
    if ((pkt.dest_x == X_EDGE_WEST || pkt.dest_x == X_EDGE_EAST) &&
        pkt.dest_y != TILE_Y) begin
      // edge packets must reach their row before they leave sideways
      dir = (pkt.dest_y < TILE_Y) ? DIR_N : DIR_S;
    end else if (pkt.dest_x == X_EDGE_WEST) begin
      dir = DIR_W;
    end else if (pkt.dest_x == X_EDGE_EAST) begin
      dir = DIR_E;
    end else if (pkt.dest_x > TILE_X) begin
      dir = DIR_E;
    end else if (pkt.dest_x < TILE_X) begin
      dir = DIR_W;
    end else if (pkt.dest_y < TILE_Y) begin
      dir = DIR_N;
    end else begin
      // own column, cache rows lie beyond the mesh
      dir = DIR_S;
    end
    return dir;
  endfunction

  // first requester at or after the pointer
  function automatic logic [1:0] rr_pick(logic [3:0] req_v, logic [1:0] ptr);
    logic [1:0] idx;
    logic [1:0] pick;
    logic       found;
    pick  = ptr;
    found = 1'b0;
    for (int k = 0; k < 4; k++) begin
      idx = ptr + 2'(k);
      if (!found && req_v[idx]) begin
        pick  = idx;
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  for (genvar i = 0; i < 4; i++) begin : g_in
    credit_fifo in_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .valid_i (valid_i[i]),
      .data_i  (data_i[i]),
      .deq_i   (deq[i]),
      .valid_o (head_valid[i]),
      .data_o  (head_data[i]),
      .credit_o(credit_o[i])
    );

    assign head_dir[i] = route_dir(head_data[i]);

    for (genvar o = 0; o < 4; o++) begin : g_req
      assign req[o][i] = head_valid[i] && (head_dir[i] == dir_e'(o));
    end

    // each head asks for one output only
    assign deq[i] = gnt[0][i] | gnt[1][i] | gnt[2][i] | gnt[3][i];
  end

  for (genvar o = 0; o < 4; o++) begin : g_out
    dir_e                    rr_q;
    logic [1:0]              pick;
    logic                    fire;
    logic [CREDIT_WIDTH-1:0] credit_q;
    logic                    valid_q;
    packet_t                 data_q;

    assign pick   = rr_pick(req[o], rr_q);
    assign fire   = (|req[o]) && (credit_q != '0);
    assign gnt[o] = fire ? (4'b0001 << pick) : 4'b0000;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        rr_q     <= DIR_N;
        credit_q <= CREDIT_WIDTH'(FIFO_DEPTH);
        valid_q  <= 1'b0;
      end else begin
        valid_q  <= fire;
        // spend on send, regain on each returned pulse
        credit_q <= credit_q - fire + credit_i[o];
        if (fire) begin
          rr_q <= dir_e'(pick + 2'd1);
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (fire) begin
        data_q <= head_data[pick];
      end
    end

    assign valid_o[o] = valid_q;
    assign data_o[o]  = data_q;
  end

endmodule

`default_nettype wire

// ==== hdl/vcache_endpoint.sv ====
// cache-row memory endpoint
`timescale 1ns/10ps
`default_nettype none

module vcache_endpoint #(
  parameter logic [pod_pkg::X_CORD_WIDTH-1:0] COL_X = 2'd0,
  parameter logic [pod_pkg::Y_CORD_WIDTH-1:0] ROW_Y = 2'd0
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             valid_i,
  input  pod_pkg::packet_t data_i,
  output logic             credit_o,
  output logic             valid_o,
  output pod_pkg::packet_t data_o,
  input  logic             credit_i
);
  import pod_pkg::*;

  logic                    head_valid;
  packet_t                 head;
  logic                    is_load;
  logic                    is_store;
  logic                    send;
  logic                    pop;
  logic [CREDIT_WIDTH-1:0] credit_q;
  logic [DATA_WIDTH-1:0]   mem_q [VC_WORDS];
  logic                    valid_q;
  packet_t                 reply_q;

  credit_fifo in_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .data_i  (data_i),
    .deq_i   (pop),
    .valid_o (head_valid),
    .data_o  (head),
    .credit_o(credit_o)
  );

  assign is_load  = (head.op == OP_LOAD);
  assign is_store = (head.op == OP_STORE);

  // a load stays at the head until a reply credit is free
  assign send = head_valid && is_load && (credit_q != '0);
  assign pop  = head_valid && (!is_load || send);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int w = 0; w < VC_WORDS; w++) begin
        mem_q[w] <= '0;
      end
      credit_q <= CREDIT_WIDTH'(FIFO_DEPTH);
      valid_q  <= 1'b0;
    end else begin
      if (pop && is_store) begin
        mem_q[head.addr] <= head.data;
      end
      valid_q  <= send;
      credit_q <= credit_q - send + credit_i;
    end
  end

  // reply goes back to where the load came from
  always_ff @(posedge clk_i) begin
    if (send) begin
      reply_q.op     <= OP_REPLY;
      reply_q.dest_x <= head.src_x;
      reply_q.dest_y <= head.src_y;
      reply_q.src_x  <= COL_X;
      reply_q.src_y  <= ROW_Y;
      reply_q.addr   <= head.addr;
      reply_q.data   <= mem_q[head.addr];
    end
  end

  assign valid_o = valid_q;
  assign data_o  = reply_q;

endmodule

`default_nettype wire

// ==== hdl/manycore_pod.sv ====
// manycore pod top
`timescale 1ns/10ps
`default_nettype none

module manycore_pod (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  logic             [pod_pkg::NUM_TILES_Y-1:0] west_in_valid_i,
  input  pod_pkg::packet_t [pod_pkg::NUM_TILES_Y-1:0] west_in_data_i,
  output logic             [pod_pkg::NUM_TILES_Y-1:0] west_in_credit_o,
  input  logic             [pod_pkg::NUM_TILES_Y-1:0] east_in_valid_i,
  input  pod_pkg::packet_t [pod_pkg::NUM_TILES_Y-1:0] east_in_data_i,
  output logic             [pod_pkg::NUM_TILES_Y-1:0] east_in_credit_o,
  output logic             [pod_pkg::NUM_TILES_Y-1:0] west_out_valid_o,
  output pod_pkg::packet_t [pod_pkg::NUM_TILES_Y-1:0] west_out_data_o,
  input  logic             [pod_pkg::NUM_TILES_Y-1:0] west_out_credit_i,
  output logic             [pod_pkg::NUM_TILES_Y-1:0] east_out_valid_o,
  output pod_pkg::packet_t [pod_pkg::NUM_TILES_Y-1:0] east_out_data_o,
  input  logic             [pod_pkg::NUM_TILES_Y-1:0] east_out_credit_i
);
  import pod_pkg::*;

  // router side of every link, [row][col][dir]
  logic    [3:0] rt_vin  [NUM_TILES_Y][NUM_TILES_X];
  packet_t [3:0] rt_din  [NUM_TILES_Y][NUM_TILES_X];
  logic    [3:0] rt_cout [NUM_TILES_Y][NUM_TILES_X];
  logic    [3:0] rt_vout [NUM_TILES_Y][NUM_TILES_X];
  packet_t [3:0] rt_dout [NUM_TILES_Y][NUM_TILES_X];
  logic    [3:0] rt_cin  [NUM_TILES_Y][NUM_TILES_X];

  for (genvar y = 0; y < NUM_TILES_Y; y++) begin : g_row
    for (genvar x = 0; x < NUM_TILES_X; x++) begin : g_col
      mesh_router #(
        .TILE_X(X_CORD_WIDTH'(x)),
        .TILE_Y(Y_CORD_WIDTH'(Y_NORTH_VC + y + 1))
      ) router (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (rt_vin[y][x]),
        .data_i  (rt_din[y][x]),
        .credit_o(rt_cout[y][x]),
        .valid_o (rt_vout[y][x]),
        .data_o  (rt_dout[y][x]),
        .credit_i(rt_cin[y][x])
      );

      // pod west edge
      if (x == 0) begin : g_west
        assign rt_vin[y][x][DIR_W] = west_in_valid_i[y];
        assign rt_din[y][x][DIR_W] = west_in_data_i[y];
        assign west_in_credit_o[y] = rt_cout[y][x][DIR_W];
        assign west_out_valid_o[y] = rt_vout[y][x][DIR_W];
        assign west_out_data_o[y]  = rt_dout[y][x][DIR_W];
        assign rt_cin[y][x][DIR_W] = west_out_credit_i[y];
      end

      // pod east edge
      if (x == NUM_TILES_X-1) begin : g_east
        assign rt_vin[y][x][DIR_E] = east_in_valid_i[y];
        assign rt_din[y][x][DIR_E] = east_in_data_i[y];
        assign east_in_credit_o[y] = rt_cout[y][x][DIR_E];
        assign east_out_valid_o[y] = rt_vout[y][x][DIR_E];
        assign east_out_data_o[y]  = rt_dout[y][x][DIR_E];
        assign rt_cin[y][x][DIR_E] = east_out_credit_i[y];
      end else begin : g_hor
        assign rt_vin[y][x+1][DIR_W] = rt_vout[y][x][DIR_E];
        assign rt_din[y][x+1][DIR_W] = rt_dout[y][x][DIR_E];
        assign rt_cin[y][x][DIR_E]   = rt_cout[y][x+1][DIR_W];
        assign rt_vin[y][x][DIR_E]   = rt_vout[y][x+1][DIR_W];
        assign rt_din[y][x][DIR_E]   = rt_dout[y][x+1][DIR_W];
        assign rt_cin[y][x+1][DIR_W] = rt_cout[y][x][DIR_E];
      end

      if (y < NUM_TILES_Y-1) begin : g_ver
        assign rt_vin[y+1][x][DIR_N] = rt_vout[y][x][DIR_S];
        assign rt_din[y+1][x][DIR_N] = rt_dout[y][x][DIR_S];
        assign rt_cin[y][x][DIR_S]   = rt_cout[y+1][x][DIR_N];
        assign rt_vin[y][x][DIR_S]   = rt_vout[y+1][x][DIR_N];
        assign rt_din[y][x][DIR_S]   = rt_dout[y+1][x][DIR_N];
        assign rt_cin[y+1][x][DIR_N] = rt_cout[y][x][DIR_S];
      end
    end
  end

  // one endpoint above and one below each column
  for (genvar x = 0; x < NUM_TILES_X; x++) begin : g_vc
    vcache_endpoint #(
      .COL_X(X_CORD_WIDTH'(x)),
      .ROW_Y(Y_NORTH_VC)
    ) north_vc (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .valid_i (rt_vout[0][x][DIR_N]),
      .data_i  (rt_dout[0][x][DIR_N]),
      .credit_o(rt_cin[0][x][DIR_N]),
      .valid_o (rt_vin[0][x][DIR_N]),
      .data_o  (rt_din[0][x][DIR_N]),
      .credit_i(rt_cout[0][x][DIR_N])
    );

    vcache_endpoint #(
      .COL_X(X_CORD_WIDTH'(x)),
      .ROW_Y(Y_SOUTH_VC)
    ) south_vc (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .valid_i (rt_vout[NUM_TILES_Y-1][x][DIR_S]),
      .data_i  (rt_dout[NUM_TILES_Y-1][x][DIR_S]),
      .credit_o(rt_cin[NUM_TILES_Y-1][x][DIR_S]),
      .valid_o (rt_vin[NUM_TILES_Y-1][x][DIR_S]),
      .data_o  (rt_din[NUM_TILES_Y-1][x][DIR_S]),
      .credit_i(rt_cout[NUM_TILES_Y-1][x][DIR_S])
    );
  end

endmodule

`default_nettype wire

// ==== test/pod_tb.sv ====
// pod testbench
`timescale 1ns/10ps
`default_nettype none

module pod_tb;
  import pod_pkg::*;

  localparam int CREDIT_TIMEOUT = 400;
  localparam int DRAIN_TIMEOUT  = 1000;

  logic                              clk_i;
  logic                              rst_n_i;
  logic             [NUM_TILES_Y-1:0] west_in_valid_i;
  packet_t          [NUM_TILES_Y-1:0] west_in_data_i;
  logic             [NUM_TILES_Y-1:0] west_in_credit_o;
  logic             [NUM_TILES_Y-1:0] east_in_valid_i;
  packet_t          [NUM_TILES_Y-1:0] east_in_data_i;
  logic             [NUM_TILES_Y-1:0] east_in_credit_o;
  logic             [NUM_TILES_Y-1:0] west_out_valid_o;
  packet_t          [NUM_TILES_Y-1:0] west_out_data_o;
  logic             [NUM_TILES_Y-1:0] west_out_credit_i;
  logic             [NUM_TILES_Y-1:0] east_out_valid_o;
  packet_t          [NUM_TILES_Y-1:0] east_out_data_o;
  logic             [NUM_TILES_Y-1:0] east_out_credit_i;

  // edge ports 0,1 are west rows y=1,2 and ports 2,3 are east rows y=1,2
  logic    [3:0] in_valid;
  packet_t       in_data [4];
  logic    [3:0] in_credit;
  logic    [3:0] out_valid;
  packet_t       out_data [4];
  logic    [3:0] out_credit;
  logic    [3:0] hold;

  // scoreboard
  packet_t               exp_pkt [$];
  int                    exp_port [$];
  logic [DATA_WIDTH-1:0] shadow [4][VC_WORDS];
  int                    in_sent [4];
  int                    in_ret [4];
  int                    out_recv [4];
  int                    out_granted [4];
  int                    owed [4];
  logic [31:0]           rng_state;
  int                    errors;
  int                    tests_run;
  int                    tests_failed;
  int                    test_errors_start;

  assign west_in_valid_i   = in_valid[1:0];
  assign east_in_valid_i   = in_valid[3:2];
  assign west_in_data_i    = {in_data[1], in_data[0]};
  assign east_in_data_i    = {in_data[3], in_data[2]};
  assign in_credit         = {east_in_credit_o, west_in_credit_o};
  assign out_valid         = {east_out_valid_o, west_out_valid_o};
  assign out_data[0]       = west_out_data_o[0];
  assign out_data[1]       = west_out_data_o[1];
  assign out_data[2]       = east_out_data_o[0];
  assign out_data[3]       = east_out_data_o[1];
  assign west_out_credit_i = out_credit[1:0];
  assign east_out_credit_i = out_credit[3:2];

  manycore_pod UUT (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .west_in_valid_i  (west_in_valid_i),
    .west_in_data_i   (west_in_data_i),
    .west_in_credit_o (west_in_credit_o),
    .east_in_valid_i  (east_in_valid_i),
    .east_in_data_i   (east_in_data_i),
    .east_in_credit_o (east_in_credit_o),
    .west_out_valid_o (west_out_valid_o),
    .west_out_data_o  (west_out_data_o),
    .west_out_credit_i(west_out_credit_i),
    .east_out_valid_o (east_out_valid_o),
    .east_out_data_o  (east_out_data_o),
    .east_out_credit_i(east_out_credit_i)
  );

  function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic packet_t make_pkt(op_e op, logic [X_CORD_WIDTH-1:0] dx,
                                       logic [Y_CORD_WIDTH-1:0] dy,
                                       logic [X_CORD_WIDTH-1:0] sx,
                                       logic [Y_CORD_WIDTH-1:0] sy,
                                       logic [ADDR_WIDTH-1:0] addr,
                                       logic [DATA_WIDTH-1:0] data);
    packet_t pkt;
    pkt.op     = op;
    pkt.dest_x = dx;
    pkt.dest_y = dy;
    pkt.src_x  = sx;
    pkt.src_y  = sy;
    pkt.addr   = addr;
    pkt.data   = data;
    return pkt;
  endfunction

  function automatic logic [X_CORD_WIDTH-1:0] port_x(int p);
    return (p < 2) ? X_EDGE_WEST : X_EDGE_EAST;
  endfunction

  function automatic logic [Y_CORD_WIDTH-1:0] port_y(int p);
    return Y_CORD_WIDTH'(p % 2 + 1);
  endfunction

  // endpoints 0,1 are north cols 0,1 and endpoints 2,3 are south cols 0,1
  function automatic logic [Y_CORD_WIDTH-1:0] ep_y(int e);
    return (e < 2) ? Y_NORTH_VC : Y_SOUTH_VC;
  endfunction

  task automatic stop_on_timeout(string what);
    $display("timeout while waiting for %s at %0t ns", what, $time);
    $display("tests failed");
    $finish;
  endtask

  task automatic send_pkt(int p, packet_t pkt);
    int cycles;
    cycles = 0;
    while (FIFO_DEPTH + in_ret[p] - in_sent[p] <= 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > CREDIT_TIMEOUT) begin
        stop_on_timeout("an input credit");
      end
    end
    in_valid[p] = 1'b1;
    in_data[p]  = pkt;
    in_sent[p]++;
    @(negedge clk_i);
    in_valid[p] = 1'b0;
  endtask

  task automatic expect_pkt(int p, packet_t pkt);
    exp_pkt.push_back(pkt);
    exp_port.push_back(p);
  endtask

  task automatic do_load(int p, int e, logic [ADDR_WIDTH-1:0] addr);
    // reply returns to the load's source with the endpoint as its source
    expect_pkt(p, make_pkt(OP_REPLY, port_x(p), port_y(p), X_CORD_WIDTH'(e % 2),
                           ep_y(e), addr, shadow[e][addr]));
    send_pkt(p, make_pkt(OP_LOAD, X_CORD_WIDTH'(e % 2), ep_y(e), port_x(p),
                         port_y(p), addr, '0));
  endtask

  task automatic store_then_load(int p, int e, logic [ADDR_WIDTH-1:0] addr);
    logic [DATA_WIDTH-1:0] data;
    data = DATA_WIDTH'(xorshift());
    shadow[e][addr] = data;
    send_pkt(p, make_pkt(OP_STORE, X_CORD_WIDTH'(e % 2), ep_y(e), port_x(p),
                         port_y(p), addr, data));
    do_load(p, e, addr);
  endtask

  task automatic send_stream(int p, int q, int n);
    packet_t pkt;
    op_e     op;
    for (int i = 0; i < n; i++) begin
      if (i % 2 == 0) begin
        op = OP_STORE;
      end else begin
        op = OP_LOAD;
      end
      pkt = make_pkt(op, port_x(q), port_y(q), port_x(p), port_y(p),
                     ADDR_WIDTH'(xorshift()), DATA_WIDTH'(xorshift()));
      expect_pkt(q, pkt);
      send_pkt(p, pkt);
    end
  endtask

  task automatic wait_drain(string what);
    int cycles;
    cycles = 0;
    while (exp_pkt.size() != 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > DRAIN_TIMEOUT) begin
        stop_on_timeout(what);
      end
    end
    // room for stray packets to show up
    repeat (10) @(negedge clk_i);
  endtask

  task automatic end_test(int num, string name);
    tests_run++;
    if (errors == test_errors_start) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAIL", num, name);
    end
    test_errors_start = errors;
  endtask

  // match each output packet with the oldest one expected on its port and return a credit
  always @(negedge clk_i) begin : monitor
    int idx;
    if (rst_n_i) begin
      for (int p = 0; p < 4; p++) begin
        if (in_credit[p]) begin
          in_ret[p]++;
        end
        if (out_valid[p]) begin
          out_recv[p]++;
          assert (out_recv[p] <= out_granted[p]) else begin
            $display("** Error at %0t: port %0d valid without a granted credit", $time, p);
            errors++;
          end
          idx = -1;
          for (int i = exp_port.size() - 1; i >= 0; i--) begin
            if (exp_port[i] == p) begin
              idx = i;
            end
          end
          assert (idx >= 0) else begin
            $display("port %0d sent a packet that was not expected at %0t ns", p, $time);
            errors++;
          end
          if (idx >= 0) begin
            assert (out_data[p] == exp_pkt[idx]) else begin
              $display("** Error at %0t: port %0d got %h, expected %h", $time, p,
                       out_data[p], exp_pkt[idx]);
              errors++;
            end
            exp_pkt.delete(idx);
            exp_port.delete(idx);
          end
          owed[p]++;
        end
        if (owed[p] > 0 && !hold[p]) begin
          out_credit[p] = 1'b1;
          owed[p]--;
          out_granted[p]++;
        end else begin
          out_credit[p] = 1'b0;
        end
      end
    end
  end

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    int recv_start;
    rst_n_i           = 1'b0;
    in_valid          = '0;
    out_credit        = '0;
    hold              = '0;
    rng_state         = 32'd8775;
    errors            = 0;
    tests_run         = 0;
    tests_failed      = 0;
    test_errors_start = 0;
    for (int p = 0; p < 4; p++) begin
      in_data[p]     = '0;
      in_sent[p]     = 0;
      in_ret[p]      = 0;
      out_recv[p]    = 0;
      out_granted[p] = FIFO_DEPTH;
      owed[p]        = 0;
      for (int a = 0; a < VC_WORDS; a++) begin
        shadow[p][a] = '0;
      end
    end
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    repeat (20) begin
      @(negedge clk_i);
      assert (out_valid == 4'b0000 && in_credit == 4'b0000) else begin
        $display("** Error at %0t: output valid or credit high after reset", $time);
        errors++;
      end
    end
    end_test(1, "reset");

    fork
      store_then_load(0, 0, 4'd3);
      store_then_load(1, 1, 4'd3);
      store_then_load(2, 2, 4'd3);
      store_then_load(3, 3, 4'd3);
    join
    wait_drain("load replies");
    end_test(2, "store then load");

    // same address in every endpoint, plus a word never written
    fork
      store_then_load(1, 0, 4'd7);
      store_then_load(2, 1, 4'd7);
      store_then_load(3, 2, 4'd7);
      store_then_load(0, 3, 4'd7);
    join
    fork
      do_load(1, 0, 4'd15);
      do_load(2, 1, 4'd15);
      do_load(3, 2, 4'd15);
      do_load(0, 3, 4'd15);
    join
    wait_drain("endpoint replies");
    end_test(3, "endpoint independence");

    fork
      send_stream(0, 3, 6);
      send_stream(1, 2, 6);
      send_stream(2, 0, 6);
      send_stream(3, 1, 6);
    join
    wait_drain("edge passthrough packets");
    end_test(4, "edge passthrough");

    hold[2]    = 1'b1;
    recv_start = out_recv[2];
    fork
      send_stream(0, 2, 3 * FIFO_DEPTH + 2);
      begin
        repeat (80) @(negedge clk_i);
        assert (out_recv[2] - recv_start <= FIFO_DEPTH) else begin
          $display("** Error at %0t: %0d packets arrived while credits were held",
                   $time, out_recv[2] - recv_start);
          errors++;
        end
        hold[2] = 1'b0;
      end
    join
    wait_drain("back-pressured packets");
    end_test(5, "back-pressure");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/pod_pkg.sv
hdl/credit_fifo.sv
hdl/mesh_router.sv
hdl/vcache_endpoint.sv
hdl/manycore_pod.sv
test/pod_tb.sv
